// File: spi_master.f
+incdir+hdl
hdl/spi_master_pkg.sv
hdl/spi_clkgen.sv
hdl/spi_phase_ctrl.sv
hdl/spi_tx_shifter.sv
hdl/spi_rx_shifter.sv
hdl/spi_master_top.sv
verif/tb_clkgen.sv
verif/tb_spi_master.sv

// File: verif/spi_master_cases.txt
// op(0 wr 1 rd) csreg clk_div cmd_len cmd addr_len addr data_len data0 data1
// stall exp_rx0 exp_rx1, all hex, one frame per line
0 1 0 08 9F000000 00 00000000 0010 A5C30000 00000000 0 00000000 00000000
0 2 1 08 02000000 18 00123400 0020 DEADBEEF 00000000 0 00000000 00000000
0 4 2 00 00000000 20 CAFEBABE 0028 12345678 9ABCDEF0 0 00000000 00000000
0 8 0 20 01234567 10 ABCD0000 0040 0F1E2D3C 4B5A6978 1 00000000 00000000
0 3 3 04 F0000000 00 00000000 0000 00000000 00000000 0 00000000 00000000
1 1 0 08 0B000000 18 00010000 0020 12345678 00000000 0 12345678 00000000
1 2 1 08 03000000 00 00000000 0028 12345678 9ABCDEF0 0 12345678 0000009A
1 4 0 00 00000000 00 00000000 0014 12345678 00000000 0 00012345 00000000
1 F 2 08 3B000000 10 80000000 0040 CAFEF00D DEADBEEF 1 CAFEF00D DEADBEEF
1 1 0 08 05000000 00 00000000 0001 80000000 00000000 0 00000001 00000000
0 F 0 00 00000000 00 00000000 0000 00000000 00000000 0 00000000 00000000
0 1 1 00 00000000 00 00000000 0040 11223344 55667788 1 00000000 00000000
1 2 0 08 6B000000 18 20000000 0024 CAFEF00D DEADBEEF 1 CAFEF00D 0000000D
0 8 4 20 FFFFFFFF 20 00000000 0001 80000000 00000000 0 00000000 00000000

// File: verif/tb_spi_master.sv
// SPI master testbench
// reads frames from a case file, plays the SPI slave, feeds and drains
// the word streams and checks bits, words, chip selects and clock timing

`timescale 1ns/1ps
`default_nettype none

`include "spi_master_settings.svh"

module tb_spi_master;

  localparam int FIELDS    = 13;
  localparam int MAX_CASES = 32;

  logic                  clk;
  logic                  rstn;
  logic                  rd;
  logic                  wr;
  logic [31:0]           cmd;
  logic [`SPI_LEN_W-1:0] cmd_len;
  logic [31:0]           addr;
  logic [`SPI_LEN_W-1:0] addr_len;
  logic [15:0]           data_len;
  logic [`SPI_CS_N-1:0]  csreg;
  logic [`SPI_DIV_W-1:0] clk_div;
  logic                  clk_div_valid;
  logic [31:0]           tx_data;
  logic                  tx_valid;
  logic                  tx_ready;
  logic [31:0]           rx_data;
  logic                  rx_valid;
  logic                  rx_ready;
  logic                  eot;
  logic [4:0]            status;
  logic                  spi_clk;
  logic [`SPI_CS_N-1:0]  csn;
  logic                  sdo;
  logic                  sdi;

  logic [31:0]          case_mem [0:FIELDS*MAX_CASES-1];
  int                   n_cases;
  int                   n_failed;
  int                   errors;
  int                   limit;
  int                   seed;
  int                   eot_cnt;
  int                   half;
  int                   cur_clen;
  int                   cur_alen;
  int                   cur_dlen;
  int                   cur_div;
  logic [`SPI_CS_N-1:0] cur_cs;
  logic [31:0]          cur_cmd;
  logic [31:0]          cur_addr;
  logic [31:0]          cur_d0;
  logic [31:0]          cur_d1;
  logic                 cur_stall;
  logic                 rx_stall;
  logic                 tx_fire;
  logic                 prev_wait;
  logic                 meas;
  logic                 lvl;
  bit                   sdo_bits[$];
  logic [31:0]          rx_got[$];

  tb_clkgen i_clkgen (.clk(clk), .rstn(rstn));

  spi_master_top i_dut (
    .clk(clk), .rstn(rstn), .rd(rd), .wr(wr),
    .cmd(cmd), .cmd_len(cmd_len), .addr(addr), .addr_len(addr_len),
    .data_len(data_len), .csreg(csreg), .clk_div(clk_div),
    .clk_div_valid(clk_div_valid), .tx_data(tx_data), .tx_valid(tx_valid),
    .tx_ready(tx_ready), .rx_data(rx_data), .rx_valid(rx_valid),
    .rx_ready(rx_ready), .eot(eot), .status(status), .spi_clk(spi_clk),
    .csn(csn), .sdo(sdo), .sdi(sdi)
  );

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %0t ns %s: got %h expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_error(input string what);
    $display("%0t ns: %s", $time, what);
    errors++;
  endtask

  // slave side: record sdo at each rising spi_clk
  always @(posedge spi_clk)
    sdo_bits.push_back(sdo);

  // read data goes out msb first once command and address bits have passed
  always @(negedge clk)
  begin
    int idx;
    logic [63:0] stream;
    idx    = sdo_bits.size() - (cur_clen + cur_alen);
    stream = {cur_d0, cur_d1};
    sdi    = (idx >= 0 && idx < 64) ? stream[63-idx] : 1'b0;
    rx_ready = rx_stall ? (($unsigned($random(seed)) % 3) == 0) : 1'b1;
  end

  // stream handshakes, chip selects, status and spi_clk half periods
  always @(posedge clk)
  begin
    if (!rstn)
    begin
      tx_fire   <= 1'b0;
      prev_wait = 1'b0;
      meas      = 1'b0;
      lvl       = 1'b0;
      half      = 0;
    end
    else
    begin
      tx_fire <= tx_valid && tx_ready;
      if (rx_valid && rx_ready)
        rx_got.push_back(rx_data);
      if (eot)
        eot_cnt++;
      if ($countones(status) != 1)
        report_error($sformatf("status %b is not one-hot", status));
      if (!status[0] && csn !== ~cur_cs)
        report_mismatch("csn", 32'(csn), 32'(~cur_cs));
      if (status[0] && csn !== '1)
        report_mismatch("csn", 32'(csn), 32'hf);
      if (prev_wait && tx_ready && spi_clk)
        report_error("spi_clk is high while the next transmit word is missing");
      prev_wait = tx_ready && !tx_valid;
      if (spi_clk !== lvl)
      begin
        if (meas && !cur_stall && half != cur_div + 1)
          report_mismatch("spi_clk half period", half, cur_div + 1);
        meas = 1'b1;
        half = 1;
        lvl  = spi_clk;
      end
      else
        half++;
      if (status[0] && !spi_clk)
        meas = 1'b0;
    end
  end

  task automatic feed_tx(input int n);
    int i;
    int k;
    for (i = 0; i < n; i++)
    begin
      if (cur_stall)
      begin
        k = $unsigned($random(seed)) % 6;
        repeat (k) @(negedge clk);
      end
      tx_data  = (i == 0) ? cur_d0 : cur_d1;
      tx_valid = 1'b1;
      @(negedge clk);
      while (!tx_fire)
        @(negedge clk);
      tx_valid = 1'b0;
    end
  endtask

  task automatic run_case(input int c);
    int          base;
    int          nw;
    int          pre;
    int          i;
    int          err0;
    logic        is_rd;
    logic        exp_bit;
    logic [63:0] stream;
    base  = c * FIELDS;
    err0  = errors;
    is_rd = case_mem[base][0];
    @(negedge clk);
    cur_cs    = case_mem[base+1][`SPI_CS_N-1:0];
    cur_div   = case_mem[base+2];
    cur_clen  = case_mem[base+3];
    cur_cmd   = case_mem[base+4];
    cur_alen  = case_mem[base+5];
    cur_addr  = case_mem[base+6];
    cur_dlen  = case_mem[base+7];
    cur_d0    = case_mem[base+8];
    cur_d1    = case_mem[base+9];
    cur_stall = case_mem[base+10][0];
    csreg         = cur_cs;
    clk_div       = cur_div[`SPI_DIV_W-1:0];
    clk_div_valid = 1'b1;
    cmd           = cur_cmd;
    cmd_len       = cur_clen[`SPI_LEN_W-1:0];
    addr          = cur_addr;
    addr_len      = cur_alen[`SPI_LEN_W-1:0];
    data_len      = cur_dlen[15:0];
    @(negedge clk);
    clk_div_valid = 1'b0;
    sdo_bits.delete();
    rx_got.delete();
    eot_cnt  = 0;
    rx_stall = is_rd && cur_stall;
    pre      = cur_clen + cur_alen;
    nw       = (cur_dlen + 31) / 32;
    rd       = is_rd;
    wr       = !is_rd;
    if (!is_rd)
      fork
        feed_tx(nw);
      join_none
    @(negedge clk);
    rd = 1'b0;
    wr = 1'b0;
    if (pre + cur_dlen == 0)
      repeat (40) @(negedge clk);
    else
    begin
      while (eot_cnt == 0)
        @(negedge clk);
      wait fork;
      i = 0;
      while (is_rd && rx_got.size() < nw && i < 200)
      begin
        @(negedge clk);
        i++;
      end
      repeat (4) @(negedge clk);
    end
    rx_stall = 1'b0;

    if (eot_cnt != ((pre + cur_dlen == 0) ? 0 : 1))
      report_mismatch("eot pulses", eot_cnt, (pre + cur_dlen == 0) ? 0 : 1);
    stream = {cur_d0, cur_d1};
    if (sdo_bits.size() != pre + cur_dlen)
      report_mismatch("sdo bit count", sdo_bits.size(), pre + cur_dlen);
    else
      for (i = 0; i < (is_rd ? pre : pre + cur_dlen); i++)
      begin
        if (i < cur_clen)
          exp_bit = cur_cmd[31-i];
        else if (i < pre)
          exp_bit = cur_addr[31-(i-cur_clen)];
        else
          exp_bit = stream[63-(i-pre)];
        if (sdo_bits[i] !== exp_bit)
        begin
          report_mismatch($sformatf("sdo bit %0d", i), sdo_bits[i], exp_bit);
          break;
        end
      end
    if (is_rd && rx_got.size() != nw)
      report_mismatch("rx word count", rx_got.size(), nw);
    else if (is_rd)
    begin
      if (nw > 0 && rx_got[0] !== case_mem[base+11])
        report_mismatch("rx_data word 0", rx_got[0], case_mem[base+11]);
      if (nw > 1 && rx_got[1] !== case_mem[base+12])
        report_mismatch("rx_data word 1", rx_got[1], case_mem[base+12]);
    end
    if (!is_rd && rx_got.size() != 0)
      report_error("a write frame produced receive words");
    if (errors != err0)
      n_failed++;
    $display("case %0d %s len %0d/%0d/%0d: %s", c, is_rd ? "read" : "write",
             cur_clen, cur_alen, cur_dlen, (errors == err0) ? "ok" : "bad");
  endtask

  // run length grows with the slowest divider in the case file
  initial
  begin
    wait (limit > 0);
    repeat (limit) @(posedge clk);
    $display("watchdog expired before all cases finished");
    $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    int c;
    int maxdiv;
    rd = 1'b0;
    wr = 1'b0;
    cmd = '0;
    cmd_len = '0;
    addr = '0;
    addr_len = '0;
    data_len = '0;
    csreg = '0;
    clk_div = '0;
    clk_div_valid = 1'b0;
    tx_data = '0;
    tx_valid = 1'b0;
    rx_ready = 1'b0;
    sdi = 1'b0;
    cur_cs = '0;
    cur_div = 0;
    cur_clen = 0;
    cur_alen = 0;
    cur_dlen = 0;
    cur_d0 = '0;
    cur_d1 = '0;
    cur_stall = 1'b0;
    rx_stall = 1'b0;
    seed = 92115;
    errors = 0;
    n_failed = 0;
    eot_cnt = 0;
    limit = 0;
    $readmemh("verif/spi_master_cases.txt", case_mem);
    n_cases = 0;
    maxdiv = 0;
    while (n_cases < MAX_CASES && !$isunknown(case_mem[n_cases*FIELDS]))
    begin
      if (case_mem[n_cases*FIELDS+2] > maxdiv)
        maxdiv = case_mem[n_cases*FIELDS+2];
      n_cases++;
    end
    limit = n_cases * (64 + 96) * 2 * (maxdiv + 1) + 4000;
    wait (rstn);
    @(negedge clk);
    if (csn !== '1)
      report_mismatch("csn after reset", 32'(csn), 32'hf);
    if (spi_clk !== 1'b0 || eot !== 1'b0 || rx_valid !== 1'b0 || tx_ready !== 1'b0)
      report_error("spi_clk, eot, rx_valid or tx_ready not low after reset");
    if (status !== 5'b00001)
      report_mismatch("status after reset", 32'(status), 32'h1);
    for (c = 0; c < n_cases; c++)
      run_case(c);
    $display("%0d cases, %0d passed, %0d failed, %0d errors",
             n_cases, n_cases - n_failed, n_failed, errors);
    if (errors == 0 && n_cases > 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/tb_clkgen.sv
// testbench clock and reset
// 8 ns clock, reset held low for 16 cycles and released on a falling edge

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
(
  output logic clk,
  output logic rstn
);

  initial
  begin
    clk  = 1'b0;
    rstn = 1'b0;
    fork
      forever #4 clk = ~clk;
      begin
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
      end
    join
  end

endmodule

`default_nettype wire

// File: hdl/spi_master_top.sv
// SPI master controller top
// single-lane SPI master with command, address and data phases,
// valid/ready word streams and four chip selects

`timescale 1ns/1ps
`default_nettype none

`include "spi_master_settings.svh"

module spi_master_top
  import spi_master_pkg::*;
(
  input  wire                  clk,
  input  wire                  rstn,
  input  wire                  rd,
  input  wire                  wr,
  input  wire spi_word_t       cmd,
  input  wire [`SPI_LEN_W-1:0] cmd_len,
  input  wire spi_word_t       addr,
  input  wire [`SPI_LEN_W-1:0] addr_len,
  input  wire bit_cnt_t        data_len,
  input  wire [`SPI_CS_N-1:0]  csreg,
  input  wire [`SPI_DIV_W-1:0] clk_div,
  input  wire                  clk_div_valid,
  input  wire spi_word_t       tx_data,
  input  wire                  tx_valid,
  output logic                 tx_ready,
  output spi_word_t            rx_data,
  output logic                 rx_valid,
  input  wire                  rx_ready,
  output logic                 eot,
  output logic [4:0]           status,
  output logic                 spi_clk,
  output logic [`SPI_CS_N-1:0] csn,
  output logic                 sdo,
  input  wire                  sdi
);

  logic      spi_rise;
  logic      spi_fall;
  logic      clk_en;
  spi_word_t tx_word;
  logic      tx_word_valid;
  logic      tx_word_ready;
  bit_cnt_t  tx_len;
  logic      tx_load;
  logic      tx_en;
  logic      tx_done;
  logic      tx_clk_req;
  bit_cnt_t  rx_len;
  logic      rx_load;
  logic      rx_en;
  logic      rx_done;
  logic      rx_clk_req;

  spi_clkgen i_clkgen (
    .clk           (clk),
    .rstn          (rstn),
    .en            (clk_en),
    .clk_div       (clk_div),
    .clk_div_valid (clk_div_valid),
    .spi_clk       (spi_clk),
    .spi_rise      (spi_rise),
    .spi_fall      (spi_fall)
  );

  spi_phase_ctrl i_phase_ctrl (
    .clk           (clk),
    .rstn          (rstn),
    .rd            (rd),
    .wr            (wr),
    .cmd           (cmd),
    .cmd_len       (cmd_len),
    .addr          (addr),
    .addr_len      (addr_len),
    .data_len      (data_len),
    .csreg         (csreg),
    .tx_data       (tx_data),
    .tx_valid      (tx_valid),
    .tx_word_ready (tx_word_ready),
    .tx_done       (tx_done),
    .tx_clk_req    (tx_clk_req),
    .rx_done       (rx_done),
    .rx_clk_req    (rx_clk_req),
    .spi_fall      (spi_fall),
    .tx_ready      (tx_ready),
    .tx_word       (tx_word),
    .tx_word_valid (tx_word_valid),
    .tx_len        (tx_len),
    .tx_load       (tx_load),
    .tx_en         (tx_en),
    .rx_len        (rx_len),
    .rx_load       (rx_load),
    .rx_en         (rx_en),
    .clk_en        (clk_en),
    .csn           (csn),
    .status        (status),
    .eot           (eot)
  );

  spi_tx_shifter i_tx_shifter (
    .clk           (clk),
    .rstn          (rstn),
    .en            (tx_en),
    .tx_len        (tx_len),
    .tx_load       (tx_load),
    .tx_word       (tx_word),
    .tx_word_valid (tx_word_valid),
    .spi_fall      (spi_fall),
    .tx_word_ready (tx_word_ready),
    .tx_done       (tx_done),
    .tx_clk_req    (tx_clk_req),
    .sdo           (sdo)
  );

  spi_rx_shifter i_rx_shifter (
    .clk        (clk),
    .rstn       (rstn),
    .en         (rx_en),
    .rx_len     (rx_len),
    .rx_load    (rx_load),
    .sdi        (sdi),
    .spi_rise   (spi_rise),
    .rx_ready   (rx_ready),
    .rx_data    (rx_data),
    .rx_valid   (rx_valid),
    .rx_done    (rx_done),
    .rx_clk_req (rx_clk_req)
  );

endmodule

`default_nettype wire

// File: hdl/spi_rx_shifter.sv
// SPI receive shifter
// samples sdi on each rising strobe, packs the bits into 32-bit words
// and offers each word, or the right-aligned leftover, on a valid/ready stream

`timescale 1ns/1ps
`default_nettype none

`include "spi_master_settings.svh"

module spi_rx_shifter
  import spi_master_pkg::*;
(
  input  wire           clk,
  input  wire           rstn,
  input  wire           en,
  input  wire bit_cnt_t rx_len,
  input  wire           rx_load,
  input  wire           sdi,
  input  wire           spi_rise,
  input  wire           rx_ready,
  output spi_word_t     rx_data,
  output logic          rx_valid,
  output logic          rx_done,
  output logic          rx_clk_req
);

  spi_word_t             shift_q;
  spi_word_t             shift_next;
  bit_cnt_t              cnt_q;
  logic [`SPI_LEN_W-1:0] bits_q;
  logic                  sample;
  logic                  word_last;

  assign sample     = en && spi_rise && (cnt_q != '0);
  assign word_last  = (bits_q == `SPI_LEN_W'(`SPI_WORD_W - 1)) || (cnt_q == 1);
  assign shift_next = {shift_q[`SPI_WORD_W-2:0], sdi};
  assign rx_done    = sample && (cnt_q == 1);

  // stop spi_clk before a second word completes while the first still waits
  assign rx_clk_req = !(rx_valid && !rx_ready && word_last && cnt_q != '0);

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cnt_q    <= '0;
      bits_q   <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      if (rx_load)
      begin
        cnt_q  <= rx_len;
        bits_q <= '0;
      end
      else if (sample)
      begin
        cnt_q  <= cnt_q - 1'b1;
        bits_q <= word_last ? '0 : bits_q + 1'b1;
      end
      if (sample && word_last)
        rx_valid <= 1'b1;
      else if (rx_ready)
        rx_valid <= 1'b0;
    end
  end

  // clearing per word keeps the upper bits of a short last word at zero
  always_ff @(posedge clk)
  begin
    if (rx_load)
      shift_q <= '0;
    else if (sample)
      shift_q <= word_last ? '0 : shift_next;
    if (sample && word_last)
      rx_data <= shift_next;
  end

  assert property (@(posedge clk) disable iff (!rstn)
    rx_valid && !rx_ready |=> rx_valid && $stable(rx_data));

endmodule

`default_nettype wire

// File: hdl/spi_tx_shifter.sv
// SPI transmit shifter
// holds the outgoing word and the remaining bit count, shifts one bit out
// msb first on each falling strobe and fetches the next word every 32 bits

`timescale 1ns/1ps
`default_nettype none

`include "spi_master_settings.svh"

module spi_tx_shifter
  import spi_master_pkg::*;
(
  input  wire            clk,
  input  wire            rstn,
  input  wire            en,
  input  wire bit_cnt_t  tx_len,
  input  wire            tx_load,
  input  wire spi_word_t tx_word,
  input  wire            tx_word_valid,
  input  wire            spi_fall,
  output logic           tx_word_ready,
  output logic           tx_done,
  output logic           tx_clk_req,
  output logic           sdo
);

  spi_word_t             shift_q;
  bit_cnt_t              cnt_q;
  logic [`SPI_LEN_W-1:0] word_bits_q;
  logic                  full_q;
  logic                  shift_now;
  logic                  release_word;
  logic                  take;

  assign shift_now    = en && spi_fall && full_q;
  assign release_word = (word_bits_q == 1) || (cnt_q == 1);
  assign take         = tx_word_ready && tx_word_valid;
  assign tx_done      = shift_now && (cnt_q == 1);
  assign tx_clk_req   = full_q;
  assign sdo          = full_q && shift_q[`SPI_WORD_W-1];

  // the next word is taken at the fall that sends the last bit of the current one
  always_comb
  begin
    if (tx_load)
      tx_word_ready = en && (tx_len != '0);
    else
      tx_word_ready = en && (cnt_q != '0) &&
                      (!full_q || (shift_now && release_word && cnt_q != 1));
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cnt_q       <= '0;
      word_bits_q <= '0;
      full_q      <= 1'b0;
    end
    else if (tx_load)
    begin
      cnt_q       <= tx_len;
      full_q      <= take;
      word_bits_q <= `SPI_LEN_W'(`SPI_WORD_W);
    end
    else if (shift_now)
    begin
      cnt_q <= cnt_q - 1'b1;
      if (release_word)
      begin
        full_q      <= take;
        word_bits_q <= `SPI_LEN_W'(`SPI_WORD_W);
      end
      else
        word_bits_q <= word_bits_q - 1'b1;
    end
    else if (take)
    begin
      full_q      <= 1'b1;
      word_bits_q <= `SPI_LEN_W'(`SPI_WORD_W);
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
      shift_q <= tx_word;
    else if (shift_now)
      shift_q <= shift_q << 1;
  end

  // a held word always has bits left to send
  assert property (@(posedge clk) disable iff (!rstn) full_q |-> (cnt_q != '0));

endmodule

`default_nettype wire

// File: hdl/spi_phase_ctrl.sv
// SPI phase sequencer
// decodes a read or write request into command, address and data phases,
// feeds the shifters with lengths and words, drives the chip selects,
// the clock enable, the phase status and the end-of-transfer pulse

`timescale 1ns/1ps
`default_nettype none

`include "spi_master_settings.svh"

module spi_phase_ctrl
  import spi_master_pkg::*;
(
  input  wire                  clk,
  input  wire                  rstn,
  input  wire                  rd,
  input  wire                  wr,
  input  wire spi_word_t       cmd,
  input  wire [`SPI_LEN_W-1:0] cmd_len,
  input  wire spi_word_t       addr,
  input  wire [`SPI_LEN_W-1:0] addr_len,
  input  wire bit_cnt_t        data_len,
  input  wire [`SPI_CS_N-1:0]  csreg,
  input  wire spi_word_t       tx_data,
  input  wire                  tx_valid,
  input  wire                  tx_word_ready,
  input  wire                  tx_done,
  input  wire                  tx_clk_req,
  input  wire                  rx_done,
  input  wire                  rx_clk_req,
  input  wire                  spi_fall,
  output logic                 tx_ready,
  output spi_word_t            tx_word,
  output logic                 tx_word_valid,
  output bit_cnt_t             tx_len,
  output logic                 tx_load,
  output logic                 tx_en,
  output bit_cnt_t             rx_len,
  output logic                 rx_load,
  output logic                 rx_en,
  output logic                 clk_en,
  output logic [`SPI_CS_N-1:0] csn,
  output logic [4:0]           status,
  output logic                 eot
);

  spi_phase_e state_q;
  spi_phase_e state_d;
  spi_phase_e enter_ph;
  tx_src_e    src;
  logic       is_rd_q;
  logic       advance;

  // first phase after cur whose length is not zero
  function automatic spi_phase_e next_phase(input spi_phase_e cur, input logic is_rd);
    if (cur == PH_IDLE && cmd_len != '0)
      return PH_CMD;
    else if (cur != PH_ADDR && addr_len != '0)
      return PH_ADDR;
    else if (data_len != '0)
      return is_rd ? PH_DATA_RX : PH_DATA_TX;
    else
      return PH_IDLE;
  endfunction

  always_comb
  begin
    state_d  = state_q;
    enter_ph = PH_IDLE;
    advance  = 1'b0;
    src      = SRC_NONE;
    tx_load  = 1'b0;
    tx_len   = '0;
    tx_en    = 1'b0;
    rx_load  = 1'b0;
    rx_len   = '0;
    rx_en    = 1'b0;
    clk_en   = 1'b0;
    case (state_q)
      PH_IDLE:
        if (rd || wr)
        begin
          enter_ph = next_phase(PH_IDLE, rd);
          advance  = 1'b1;
        end
      PH_CMD, PH_ADDR:
      begin
        src    = (state_q == PH_CMD) ? SRC_CMD : SRC_ADDR;
        tx_en  = 1'b1;
        clk_en = tx_clk_req;
        if (tx_done)
        begin
          enter_ph = next_phase(state_q, is_rd_q);
          advance  = 1'b1;
        end
      end
      PH_DATA_TX:
      begin
        src    = SRC_FIFO;
        tx_en  = 1'b1;
        clk_en = tx_clk_req;
        if (tx_done)
          state_d = PH_IDLE;
      end
      PH_DATA_RX:
      begin
        rx_en  = 1'b1;
        clk_en = rx_clk_req;
        if (rx_done)
          state_d = PH_WAIT_EDGE;
      end
      PH_WAIT_EDGE:
      begin
        // let spi_clk fall once more after the last sampled bit
        clk_en = 1'b1;
        if (spi_fall)
          state_d = PH_IDLE;
      end
      default:
        state_d = PH_IDLE;
    endcase

    // the next phase gets its length and first word in the cycle of the last fall
    if (advance)
    begin
      state_d = enter_ph;
      case (enter_ph)
        PH_CMD:
        begin
          src     = SRC_CMD;
          tx_load = 1'b1;
          tx_en   = 1'b1;
          tx_len  = bit_cnt_t'(cmd_len);
        end
        PH_ADDR:
        begin
          src     = SRC_ADDR;
          tx_load = 1'b1;
          tx_en   = 1'b1;
          tx_len  = bit_cnt_t'(addr_len);
        end
        PH_DATA_TX:
        begin
          src     = SRC_FIFO;
          tx_load = 1'b1;
          tx_en   = 1'b1;
          tx_len  = data_len;
        end
        PH_DATA_RX:
        begin
          rx_load = 1'b1;
          rx_en   = 1'b1;
          rx_len  = data_len;
        end
        default: ;
      endcase
    end
  end

  always_comb
  begin
    tx_word       = '0;
    tx_word_valid = 1'b0;
    tx_ready      = 1'b0;
    case (src)
      SRC_CMD:
      begin
        tx_word       = cmd;
        tx_word_valid = 1'b1;
      end
      SRC_ADDR:
      begin
        tx_word       = addr;
        tx_word_valid = 1'b1;
      end
      SRC_FIFO:
      begin
        tx_word       = tx_data;
        tx_word_valid = tx_valid;
        tx_ready      = tx_word_ready;
      end
      default: ;
    endcase
  end

  always_comb
  begin
    status = '0;
    case (state_q)
      PH_CMD:                   status[1] = 1'b1;
      PH_ADDR:                  status[2] = 1'b1;
      PH_DATA_TX:               status[3] = 1'b1;
      PH_DATA_RX, PH_WAIT_EDGE: status[4] = 1'b1;
      default:                  status[0] = 1'b1;
    endcase
  end

  assign csn = ~(csreg & {`SPI_CS_N{state_q != PH_IDLE}});

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state_q <= PH_IDLE;
      is_rd_q <= 1'b0;
      eot     <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      eot     <= (state_q != PH_IDLE) && (state_d == PH_IDLE);
      if (state_q == PH_IDLE && (rd || wr))
        is_rd_q <= rd;
    end
  end

  // a request is either a read or a write
  assert property (@(posedge clk) disable iff (!rstn) !(rd && wr));

endmodule

`default_nettype wire

// File: hdl/spi_clkgen.sv
// SPI serial clock generator
// divides clk so that each spi_clk half period lasts clk_div+1 cycles
// and flags the cycle before each rising and falling edge

`timescale 1ns/1ps
`default_nettype none

`include "spi_master_settings.svh"

module spi_clkgen
  import spi_master_pkg::*;
(
  input  wire                  clk,
  input  wire                  rstn,
  input  wire                  en,
  input  wire [`SPI_DIV_W-1:0] clk_div,
  input  wire                  clk_div_valid,
  output logic                 spi_clk,
  output logic                 spi_rise,
  output logic                 spi_fall
);

  logic [`SPI_DIV_W-1:0] div_q;
  logic [`SPI_DIV_W-1:0] cnt_q;
  logic                  toggle;

  assign toggle   = en && (cnt_q == div_q);
  assign spi_rise = toggle && !spi_clk;
  assign spi_fall = toggle && spi_clk;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      div_q   <= '0;
      cnt_q   <= '0;
      spi_clk <= 1'b0;
    end
    else
    begin
      if (clk_div_valid)
        div_q <= clk_div;
      // a stopped clock restarts with a full half period
      if (!en)
        cnt_q <= '0;
      else if (toggle)
      begin
        cnt_q   <= '0;
        spi_clk <= ~spi_clk;
      end
      else
        cnt_q <= cnt_q + 1'b1;
    end
  end

  // the divider only changes while spi_clk is stopped
  assert property (@(posedge clk) disable iff (!rstn) clk_div_valid |-> !en);

endmodule

`default_nettype wire

// File: hdl/spi_master_pkg.sv
// SPI master package
// sequencer phases, transmit word sources and the word and count types
// used across the SPI master

`default_nettype none

`include "spi_master_settings.svh"

package spi_master_pkg;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_CMD,
    PH_ADDR,
    PH_DATA_TX,
    PH_DATA_RX,
    PH_WAIT_EDGE
  } spi_phase_e;

  typedef enum logic [1:0] {SRC_NONE, SRC_CMD, SRC_ADDR, SRC_FIFO} tx_src_e;

  typedef logic [`SPI_WORD_W-1:0] spi_word_t;
  typedef logic [`SPI_DATA_LEN_W-1:0] bit_cnt_t;

endpackage

`default_nettype wire

// File: hdl/spi_master_settings.svh
// SPI master settings
// widths and counts shared by the package and the RTL of the
// single-lane SPI master controller

`ifndef SPI_MASTER_SETTINGS_SVH
`define SPI_MASTER_SETTINGS_SVH

// data, command and address words
`define SPI_WORD_W 32
// command and address bit lengths, 0 to 32
`define SPI_LEN_W 6
// data bit length and bit counters
`define SPI_DATA_LEN_W 16
`define SPI_DIV_W 8
`define SPI_CS_N 4

`endif
